/* verilog/sdram_cmd_pkg.sv */
`default_nettype none

package sdram_cmd_pkg;

  // pin order is cs_n, ras_n, cas_n, we_n.
  localparam logic [3:0] CMD_DESL      = 4'b1111;
  localparam logic [3:0] CMD_NOP       = 4'b0111;
  localparam logic [3:0] CMD_ACTIVATE  = 4'b0011;
  localparam logic [3:0] CMD_READ      = 4'b0101;
  localparam logic [3:0] CMD_WRITE     = 4'b0100;
  localparam logic [3:0] CMD_PRECHARGE = 4'b0010;
  localparam logic [3:0] CMD_REFRESH   = 4'b0001;
  localparam logic [3:0] CMD_MRS       = 4'b0000;

  // cas latency 2, sequential, burst length 1.
  localparam logic [12:0] MODE_WORD = 13'b000_0_00_010_0_000;

  localparam logic [15:0] T_INIT_WAIT = 16'd20000;
  localparam int T_RP           = 3;
  localparam int T_RCD          = 3;
  localparam int T_RFC          = 8;
  localparam int T_MRD          = 2;
  localparam int CAS_LAT        = 2;
  localparam int INIT_REFRESHES = 8;
  localparam int T_REFI         = 1560; // cycles between periodic refreshes.

  // request classes against the open-row table.
  localparam logic [1:0] KIND_HIT      = 2'd0;
  localparam logic [1:0] KIND_CLOSED   = 2'd1;
  localparam logic [1:0] KIND_CONFLICT = 2'd2;

endpackage

`default_nettype wire

/* verilog/sdram_addr_pkg.sv */
`default_nettype none

package sdram_addr_pkg;

  localparam int ADDR_W = 25;
  localparam int DATA_W = 32;
  localparam int BANK_W = 2;
  localparam int ROW_W  = 13;
  localparam int COL_W  = 10;
  localparam int BE_W   = 4;

  // cpu address is {bank, row, column}.
  function automatic logic [BANK_W-1:0] bank_of(input logic [ADDR_W-1:0] addr);
    return addr[ADDR_W-1 -: BANK_W];
  endfunction

  function automatic logic [ROW_W-1:0] row_of(input logic [ADDR_W-1:0] addr);
    return addr[COL_W +: ROW_W];
  endfunction

  function automatic logic [COL_W-1:0] col_of(input logic [ADDR_W-1:0] addr);
    return addr[COL_W-1:0];
  endfunction

endpackage

`default_nettype wire

/* verilog/sdram_init_seq.sv */
`timescale 1ns/1ps
`default_nettype none

module sdram_init_seq (
  input  logic        cpu_clk,
  input  logic        reset_n,
  output logic [3:0]  init_cmd,
  output logic [12:0] init_addr,
  output logic        init_done
);

  typedef enum logic [2:0] {S_WAIT, S_PRE, S_REF, S_MRS, S_DONE} state_t;

  state_t      state;
  logic [15:0] cnt;  // nop cycles left before the next command.
  logic [3:0]  refs; // refreshes still to issue after the current one.

  always_ff @(posedge cpu_clk or negedge reset_n) begin
    if (!reset_n) begin
      state     <= S_WAIT;
      cnt       <= sdram_cmd_pkg::T_INIT_WAIT;
      refs      <= 4'd0;
      init_cmd  <= sdram_cmd_pkg::CMD_NOP;
      init_addr <= 13'd0;
      init_done <= 1'b0;
    end else begin
      init_cmd <= sdram_cmd_pkg::CMD_NOP;
      if (cnt != 16'd0) begin
        cnt <= cnt - 16'd1;
      end else begin
        case (state)
          S_WAIT: begin
            init_cmd      <= sdram_cmd_pkg::CMD_PRECHARGE;
            init_addr[10] <= 1'b1; // all banks.
            cnt           <= 16'(sdram_cmd_pkg::T_RP);
            state         <= S_PRE;
          end
          S_PRE: begin
            init_cmd <= sdram_cmd_pkg::CMD_REFRESH;
            cnt      <= 16'(sdram_cmd_pkg::T_RFC - 1);
            refs     <= 4'(sdram_cmd_pkg::INIT_REFRESHES - 1);
            state    <= S_REF;
          end
          S_REF: begin
            if (refs == 4'd0) begin
              init_cmd  <= sdram_cmd_pkg::CMD_MRS;
              init_addr <= sdram_cmd_pkg::MODE_WORD;
              cnt       <= 16'(sdram_cmd_pkg::T_MRD);
              state     <= S_MRS;
            end else begin
              init_cmd <= sdram_cmd_pkg::CMD_REFRESH; // repeats every T_RFC cycles.
              cnt      <= 16'(sdram_cmd_pkg::T_RFC - 1);
              refs     <= refs - 4'd1;
            end
          end
          S_MRS: begin
            init_done <= 1'b1;
            state     <= S_DONE;
          end
          S_DONE: ;
          default: state <= S_WAIT;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/sdram_req_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module sdram_req_decode (
  input  logic                               cpu_clk,
  input  logic                               reset_n,
  input  logic                               read,
  input  logic                               write,
  input  logic [sdram_addr_pkg::ADDR_W-1:0]  address,
  input  logic [sdram_addr_pkg::BE_W-1:0]    be,
  input  logic [sdram_addr_pkg::DATA_W-1:0]  data_in,
  input  logic                               init_done,
  input  logic                               req_done,
  input  logic                               open_set,
  input  logic [sdram_addr_pkg::BANK_W-1:0]  open_bank,
  input  logic [sdram_addr_pkg::ROW_W-1:0]   open_row,
  input  logic                               close_one,
  input  logic [sdram_addr_pkg::BANK_W-1:0]  close_bank,
  input  logic                               close_all,
  output logic                               ready,
  output logic                               req_valid,
  output logic                               req_read,
  output logic [sdram_addr_pkg::BANK_W-1:0]  req_bank,
  output logic [sdram_addr_pkg::ROW_W-1:0]   req_row,
  output logic [sdram_addr_pkg::COL_W-1:0]   req_col,
  output logic [sdram_addr_pkg::BE_W-1:0]    req_be,
  output logic [sdram_addr_pkg::DATA_W-1:0]  req_wdata,
  output logic [1:0]                         req_kind
);

  logic [sdram_addr_pkg::ROW_W-1:0] row_tbl [4]; // open row per bank.
  logic [3:0]                       row_ok;

  assign ready = init_done && !req_valid;

  always_ff @(posedge cpu_clk or negedge reset_n) begin
    if (!reset_n) begin
      req_valid <= 1'b0;
      req_read  <= 1'b0;
    end else if (ready && (read || write)) begin
      req_valid <= 1'b1;
      req_read  <= read; // read wins when both are set.
    end else if (req_done) begin
      req_valid <= 1'b0;
    end
  end

  always_ff @(posedge cpu_clk) begin
    if (ready && (read || write)) begin
      req_bank  <= sdram_addr_pkg::bank_of(address);
      req_row   <= sdram_addr_pkg::row_of(address);
      req_col   <= sdram_addr_pkg::col_of(address);
      req_be    <= be;
      req_wdata <= data_in;
    end
  end

  always_ff @(posedge cpu_clk or negedge reset_n) begin
    if (!reset_n) begin
      row_ok <= 4'b0000;
    end else if (close_all) begin
      row_ok <= 4'b0000;
    end else begin
      if (close_one) row_ok[close_bank] <= 1'b0;
      if (open_set)  row_ok[open_bank]  <= 1'b1;
    end
  end

  always_ff @(posedge cpu_clk) begin
    if (open_set) row_tbl[open_bank] <= open_row;
  end

  always_comb begin
    if (!row_ok[req_bank])
      req_kind = sdram_cmd_pkg::KIND_CLOSED;
    else if (row_tbl[req_bank] == req_row)
      req_kind = sdram_cmd_pkg::KIND_HIT;
    else
      req_kind = sdram_cmd_pkg::KIND_CONFLICT; // another row is open in this bank.
  end

endmodule

`default_nettype wire

/* verilog/sdram_cmd_exec.sv */
`timescale 1ns/1ps
`default_nettype none

module sdram_cmd_exec (
  input  logic                               cpu_clk,
  input  logic                               reset_n,
  input  logic [3:0]                         init_cmd,
  input  logic [12:0]                        init_addr,
  input  logic                               init_done,
  input  logic                               req_valid,
  input  logic                               req_read,
  input  logic [sdram_addr_pkg::BANK_W-1:0]  req_bank,
  input  logic [sdram_addr_pkg::ROW_W-1:0]   req_row,
  input  logic [sdram_addr_pkg::COL_W-1:0]   req_col,
  input  logic [sdram_addr_pkg::BE_W-1:0]    req_be,
  input  logic [sdram_addr_pkg::DATA_W-1:0]  req_wdata,
  input  logic [1:0]                         req_kind,
  input  logic                               rd_done,
  output logic                               cs_n,
  output logic                               ras_n,
  output logic                               cas_n,
  output logic                               we_n,
  output logic                               cke,
  output logic [sdram_addr_pkg::BANK_W-1:0]  ba,
  output logic [12:0]                        addrbus_out,
  output logic [sdram_addr_pkg::BE_W-1:0]    dqm,
  output logic [sdram_addr_pkg::DATA_W-1:0]  databus_out,
  output logic                               dq_oe,
  output logic                               req_done,
  output logic                               rd_issue,
  output logic                               open_set,
  output logic [sdram_addr_pkg::BANK_W-1:0]  open_bank,
  output logic [sdram_addr_pkg::ROW_W-1:0]   open_row,
  output logic                               close_one,
  output logic [sdram_addr_pkg::BANK_W-1:0]  close_bank,
  output logic                               close_all
);

  typedef enum logic [2:0] {S_IDLE, S_RP, S_RCD, S_RD, S_REF_RP, S_REF_RFC} state_t;

  state_t                           state;
  logic [3:0]                       cmd_q;
  logic [sdram_addr_pkg::BANK_W-1:0] ba_q;
  logic [12:0]                      addr_q;
  logic [3:0]                       cnt;
  logic [10:0]                      ref_cnt;
  logic                             ref_pend;

  // init sequencer owns the pins until it finishes.
  assign {cs_n, ras_n, cas_n, we_n} = init_done ? cmd_q : init_cmd;
  assign ba          = init_done ? ba_q : '0;
  assign addrbus_out = init_done ? addr_q : init_addr;
  assign cke         = 1'b1;
  assign open_bank   = ba_q;
  assign open_row    = addr_q;
  assign close_bank  = ba_q;

  always_ff @(posedge cpu_clk or negedge reset_n) begin
    if (!reset_n) begin
      state     <= S_IDLE;
      cmd_q     <= sdram_cmd_pkg::CMD_NOP;
      ba_q      <= '0;
      addr_q    <= 13'd0;
      cnt       <= 4'd0;
      dqm       <= 4'hf;
      dq_oe     <= 1'b0;
      req_done  <= 1'b0;
      rd_issue  <= 1'b0;
      open_set  <= 1'b0;
      close_one <= 1'b0;
      close_all <= 1'b0;
    end else begin
      cmd_q     <= sdram_cmd_pkg::CMD_NOP;
      dqm       <= 4'hf;
      dq_oe     <= 1'b0;
      req_done  <= 1'b0;
      rd_issue  <= 1'b0;
      open_set  <= 1'b0;
      close_one <= 1'b0;
      close_all <= 1'b0;
      if (cnt != 4'd0) cnt <= cnt - 4'd1;
      case (state)
        S_IDLE: begin
          // the cycle after req_done leaves write recovery and lets decode drop req_valid.
          if (!req_done && ref_pend) begin
            cmd_q     <= sdram_cmd_pkg::CMD_PRECHARGE;
            addr_q    <= 13'h0400; // all banks.
            close_all <= 1'b1;
            cnt       <= 4'(sdram_cmd_pkg::T_RP - 1);
            state     <= S_REF_RP;
          end else if (!req_done && req_valid) begin
            ba_q <= req_bank;
            case (req_kind)
              sdram_cmd_pkg::KIND_CONFLICT: begin
                cmd_q     <= sdram_cmd_pkg::CMD_PRECHARGE;
                addr_q    <= 13'd0;
                close_one <= 1'b1;
                cnt       <= 4'(sdram_cmd_pkg::T_RP - 1);
                state     <= S_RP;
              end
              sdram_cmd_pkg::KIND_CLOSED: begin
                cmd_q    <= sdram_cmd_pkg::CMD_ACTIVATE;
                addr_q   <= req_row;
                open_set <= 1'b1;
                cnt      <= 4'(sdram_cmd_pkg::T_RCD - 1);
                state    <= S_RCD;
              end
              default: begin
                cnt   <= 4'd0; // row already open.
                state <= S_RCD;
              end
            endcase
          end
        end
        S_RP: begin
          if (cnt == 4'd0) begin
            cmd_q    <= sdram_cmd_pkg::CMD_ACTIVATE;
            addr_q   <= req_row;
            open_set <= 1'b1;
            cnt      <= 4'(sdram_cmd_pkg::T_RCD - 1);
            state    <= S_RCD;
          end
        end
        S_RCD: begin
          if (cnt == 4'd0) begin
            addr_q <= {{(sdram_addr_pkg::ROW_W - sdram_addr_pkg::COL_W){1'b0}}, req_col};
            if (req_read) begin
              cmd_q    <= sdram_cmd_pkg::CMD_READ;
              dqm      <= 4'h0;
              rd_issue <= 1'b1;
              state    <= S_RD;
            end else begin
              cmd_q    <= sdram_cmd_pkg::CMD_WRITE;
              dqm      <= ~req_be;
              dq_oe    <= 1'b1;
              req_done <= 1'b1;
              state    <= S_IDLE;
            end
          end
        end
        S_RD: begin
          if (rd_done) begin
            req_done <= 1'b1;
            state    <= S_IDLE;
          end
        end
        S_REF_RP: begin
          if (cnt == 4'd0) begin
            cmd_q <= sdram_cmd_pkg::CMD_REFRESH;
            cnt   <= 4'(sdram_cmd_pkg::T_RFC - 1);
            state <= S_REF_RFC;
          end
        end
        S_REF_RFC: if (cnt == 4'd0) state <= S_IDLE;
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge cpu_clk) begin
    if (state == S_RCD && cnt == 4'd0 && !req_read) databus_out <= req_wdata;
  end

  // refresh interval, counted from the last refresh issued.
  always_ff @(posedge cpu_clk or negedge reset_n) begin
    if (!reset_n) begin
      ref_cnt  <= 11'd0;
      ref_pend <= 1'b0;
    end else if (state == S_REF_RP && cnt == 4'd0) begin
      ref_cnt  <= 11'd0;
      ref_pend <= 1'b0;
    end else if (init_done && !ref_pend) begin
      if (ref_cnt == 11'(sdram_cmd_pkg::T_REFI - 1)) ref_pend <= 1'b1;
      ref_cnt <= ref_cnt + 11'd1;
    end
  end

endmodule

`default_nettype wire

/* verilog/sdram_read_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module sdram_read_capture (
  input  logic                              cpu_clk,
  input  logic                              reset_n,
  input  logic                              rd_issue,
  input  logic [sdram_addr_pkg::DATA_W-1:0] databus_in,
  output logic [sdram_addr_pkg::DATA_W-1:0] data_out,
  output logic                              rd_done
);

  // cas latency stages, rd_done is the last one.
  logic [sdram_cmd_pkg::CAS_LAT-1:0] pipe;

  always_ff @(posedge cpu_clk or negedge reset_n) begin
    if (!reset_n) begin
      pipe    <= '0;
      rd_done <= 1'b0;
    end else begin
      pipe    <= {pipe[sdram_cmd_pkg::CAS_LAT-2:0], rd_issue};
      rd_done <= pipe[sdram_cmd_pkg::CAS_LAT-1];
    end
  end

  always_ff @(posedge cpu_clk) begin
    if (pipe[sdram_cmd_pkg::CAS_LAT-1]) data_out <= databus_in; // held until the next read.
  end

endmodule

`default_nettype wire

/* verilog/sdram_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module sdram_subsystem (
  input  logic                              cpu_clk,
  input  logic                              reset_n,
  input  logic                              read,
  input  logic                              write,
  input  logic [sdram_addr_pkg::ADDR_W-1:0] address,
  input  logic [sdram_addr_pkg::BE_W-1:0]   be,
  input  logic [sdram_addr_pkg::DATA_W-1:0] data_in,
  input  logic [sdram_addr_pkg::DATA_W-1:0] databus_in,
  output logic [sdram_addr_pkg::DATA_W-1:0] data_out,
  output logic                              ready,
  output logic                              cs_n,
  output logic                              ras_n,
  output logic                              cas_n,
  output logic                              we_n,
  output logic                              cke,
  output logic [sdram_addr_pkg::BANK_W-1:0] ba,
  output logic [12:0]                       addrbus_out,
  output logic [sdram_addr_pkg::BE_W-1:0]   dqm,
  output logic [sdram_addr_pkg::DATA_W-1:0] databus_out,
  output logic                              dq_oe
);

  logic [3:0]                        init_cmd;
  logic [12:0]                       init_addr;
  logic                              init_done;
  logic                              req_valid, req_read, req_done;
  logic [sdram_addr_pkg::BANK_W-1:0] req_bank, open_bank, close_bank;
  logic [sdram_addr_pkg::ROW_W-1:0]  req_row, open_row;
  logic [sdram_addr_pkg::COL_W-1:0]  req_col;
  logic [sdram_addr_pkg::BE_W-1:0]   req_be;
  logic [sdram_addr_pkg::DATA_W-1:0] req_wdata;
  logic [1:0]                        req_kind;
  logic                              open_set, close_one, close_all;
  logic                              rd_issue, rd_done;

  sdram_init_seq u_init (.*);

  sdram_req_decode u_decode (.*);

  sdram_cmd_exec u_exec (.*);

  sdram_read_capture u_capture (.*);

endmodule

`default_nettype wire

/* verif/sdram_model.sv */
`timescale 1ns/1ps
`default_nettype none

module sdram_model (
  input  logic        cpu_clk,
  input  logic        reset_n,
  input  logic        cs_n,
  input  logic        ras_n,
  input  logic        cas_n,
  input  logic        we_n,
  input  logic        cke,
  input  logic [1:0]  ba,
  input  logic [12:0] addrbus_out,
  input  logic [3:0]  dqm,
  input  logic [31:0] databus_out,
  input  logic        dq_oe,
  output logic [31:0] databus_in
);

  logic [31:0] mem [int];      // absent words read as zero.
  logic [12:0] row_q [4];
  logic [3:0]  open_q;
  int          last_pre [4];
  int          last_act [4];
  int          last_ref, last_mrs, cyc, step, key;
  int          errors, periodic_refs, single_pre, mode_set;
  logic [31:0] rd_word, word;
  logic        rd_pend;
  logic [3:0]  cmd;

  assign cmd = {cs_n, ras_n, cas_n, we_n};

  initial begin
    databus_in = 32'd0;
    rd_pend = 1'b0;
    open_q = 4'b0;
    cyc = 0;
    step = 0;
    errors = 0;
    periodic_refs = 0;
    single_pre = 0;
    mode_set = 0;
    last_ref = -1000;
    last_mrs = -1000;
    for (int b = 0; b < 4; b++) begin
      last_pre[b] = -1000;
      last_act[b] = -1000;
    end
  end

  always @(posedge cpu_clk) begin
    cyc = cyc + 1;
    rd_pend <= 1'b0;
    if (rd_pend) databus_in <= rd_word; // cas latency after the READ.
    if (reset_n && cke !== 1'b1) begin
      errors++;
      $display("model: cke is not held high");
    end
    if (reset_n && cmd != sdram_cmd_pkg::CMD_NOP && cmd != sdram_cmd_pkg::CMD_DESL) begin
      if (cyc - last_ref < sdram_cmd_pkg::T_RFC) begin
        errors++;
        $display("model: command issued before refresh recovery ended");
      end
      if (cyc - last_mrs < sdram_cmd_pkg::T_MRD) begin
        errors++;
        $display("model: command issued too soon after mode register set");
      end
      case (cmd)
        sdram_cmd_pkg::CMD_PRECHARGE: begin
          if (addrbus_out[10]) begin
            open_q = 4'b0;
            for (int b = 0; b < 4; b++) last_pre[b] = cyc;
            if (!mode_set) begin
              if (step != 0) begin
                errors++;
                $display("model: precharge-all out of order in power-up");
              end
              step = 1;
            end
          end else begin
            open_q[ba] = 1'b0;
            last_pre[ba] = cyc;
            single_pre++;
          end
        end
        sdram_cmd_pkg::CMD_ACTIVATE: begin
          if (!mode_set) begin
            errors++;
            $display("model: ACTIVATE before mode register set");
          end
          if (open_q[ba]) begin
            errors++;
            $display("model: ACTIVATE to bank %0d with a row already open", ba);
          end
          if (cyc - last_pre[ba] < sdram_cmd_pkg::T_RP) begin
            errors++;
            $display("model: ACTIVATE too soon after PRECHARGE");
          end
          open_q[ba] = 1'b1;
          row_q[ba] = addrbus_out;
          last_act[ba] = cyc;
        end
        sdram_cmd_pkg::CMD_READ, sdram_cmd_pkg::CMD_WRITE: begin
          if (!open_q[ba]) begin
            errors++;
            $display("model: READ or WRITE to bank %0d with no open row", ba);
          end
          if (cyc - last_act[ba] < sdram_cmd_pkg::T_RCD) begin
            errors++;
            $display("model: READ or WRITE too soon after ACTIVATE");
          end
          key = int'({ba, row_q[ba], addrbus_out[9:0]});
          word = mem.exists(key) ? mem[key] : 32'd0;
          if (cmd == sdram_cmd_pkg::CMD_READ) begin
            rd_word <= word;
            rd_pend <= 1'b1;
          end else begin
            if (!dq_oe) begin
              errors++;
              $display("model: WRITE without the data bus driven");
            end
            for (int i = 0; i < 4; i++)
              if (!dqm[i]) word[8*i +: 8] = databus_out[8*i +: 8];
            mem[key] = word;
          end
        end
        sdram_cmd_pkg::CMD_REFRESH: begin
          if (open_q != 4'b0) begin
            errors++;
            $display("model: REFRESH with a bank still open");
          end
          if (!mode_set) begin
            if (step < 1 || step > sdram_cmd_pkg::INIT_REFRESHES) begin
              errors++;
              $display("model: power-up REFRESH out of order");
            end
            step++;
          end else begin
            periodic_refs++;
          end
          last_ref = cyc;
        end
        sdram_cmd_pkg::CMD_MRS: begin
          if (step != sdram_cmd_pkg::INIT_REFRESHES + 1) begin
            errors++;
            $display("model: mode register set before the power-up refreshes");
          end
          if (addrbus_out != sdram_cmd_pkg::MODE_WORD) begin
            errors++;
            $display("FAIL mode_word expected %h actual %h", sdram_cmd_pkg::MODE_WORD,
                     addrbus_out);
          end
          mode_set = 1;
          last_mrs = cyc;
        end
        default: begin
          errors++;
          $display("model: unknown command %b", cmd);
        end
      endcase
    end
    if (reset_n && dq_oe && cmd != sdram_cmd_pkg::CMD_WRITE) begin
      errors++;
      $display("model: data bus driven without a WRITE");
    end
  end

endmodule

`default_nettype wire

/* verif/sdram_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module sdram_checker (
  input logic        cpu_clk,
  input logic        reset_n,
  input logic        read,
  input logic        write,
  input logic [24:0] address,
  input logic [3:0]  be,
  input logic [31:0] data_in,
  input logic [31:0] data_out,
  input logic        ready
);

  logic [31:0] shadow [int]; // zero where never written.
  string       test_name = "none";
  string       p_name;
  int          errors = 0;
  int          reads_checked = 0;
  logic        busy = 1'b0;
  logic        p_read;
  logic [24:0] p_addr;
  logic [3:0]  p_be;
  logic [31:0] p_data;
  logic [31:0] exp_word;

  function automatic logic [31:0] expected_word(input logic [24:0] addr);
    return shadow.exists(int'(addr)) ? shadow[int'(addr)] : 32'd0;
  endfunction

  // byte lanes with be set take the new data.
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  lanes);
    logic [31:0] res;
    res = old_word;
    for (int i = 0; i < 4; i++)
      if (lanes[i]) res[8*i +: 8] = new_word[8*i +: 8];
    return res;
  endfunction

  always @(posedge cpu_clk) begin
    if (!reset_n) begin
      busy = 1'b0;
    end else begin
      if (busy && ready) begin
        busy = 1'b0;
        if (p_read) begin
          exp_word = expected_word(p_addr);
          reads_checked++;
          if (data_out !== exp_word) begin
            errors++;
            $display("FAIL %s expected %h actual %h", p_name, exp_word, data_out);
          end
        end else begin
          shadow[int'(p_addr)] = merge_bytes(expected_word(p_addr), p_data, p_be);
        end
      end
      // the next request can be taken on the edge that ends the last one.
      if (!busy && ready && (read || write)) begin
        busy = 1'b1;
        p_name = test_name;
        p_read = read; // read wins.
        p_addr = address;
        p_be = be;
        p_data = data_in;
      end
    end
  end

endmodule

`default_nettype wire

/* verif/sdram_exec_props.sv */
`timescale 1ns/1ps
`default_nettype none

module sdram_exec_props (
  input logic        cpu_clk,
  input logic        reset_n,
  input logic        cs_n,
  input logic        ras_n,
  input logic        cas_n,
  input logic        we_n,
  input logic [12:0] addrbus_out,
  input logic        dq_oe
);

  logic [3:0] cmd;
  logic [7:0] since_pre, since_act;
  logic       all_closed; // precharge-all seen, no ACTIVATE since.

  assign cmd = {cs_n, ras_n, cas_n, we_n};

  always @(posedge cpu_clk or negedge reset_n) begin
    if (!reset_n) begin
      since_pre  <= 8'hff;
      since_act  <= 8'hff;
      all_closed <= 1'b0;
    end else begin
      since_pre <= (cmd == sdram_cmd_pkg::CMD_PRECHARGE) ? 8'd1 :
                   (since_pre == 8'hff ? since_pre : since_pre + 8'd1);
      since_act <= (cmd == sdram_cmd_pkg::CMD_ACTIVATE) ? 8'd1 :
                   (since_act == 8'hff ? since_act : since_act + 8'd1);
      if (cmd == sdram_cmd_pkg::CMD_PRECHARGE && addrbus_out[10]) all_closed <= 1'b1;
      else if (cmd == sdram_cmd_pkg::CMD_ACTIVATE) all_closed <= 1'b0;
    end
  end

  a_rp: assert property (@(posedge cpu_clk) disable iff (!reset_n)
    cmd == sdram_cmd_pkg::CMD_ACTIVATE |-> since_pre >= 8'(sdram_cmd_pkg::T_RP))
    else $error("ACTIVATE sooner than T_RP after PRECHARGE");

  a_rcd: assert property (@(posedge cpu_clk) disable iff (!reset_n)
    (cmd == sdram_cmd_pkg::CMD_READ || cmd == sdram_cmd_pkg::CMD_WRITE)
    |-> since_act >= 8'(sdram_cmd_pkg::T_RCD))
    else $error("READ or WRITE sooner than T_RCD after ACTIVATE");

  a_ref: assert property (@(posedge cpu_clk) disable iff (!reset_n)
    cmd == sdram_cmd_pkg::CMD_REFRESH |-> all_closed)
    else $error("REFRESH without a preceding precharge-all");

  a_oe: assert property (@(posedge cpu_clk) disable iff (!reset_n)
    dq_oe |-> cmd == sdram_cmd_pkg::CMD_WRITE)
    else $error("dq_oe high without WRITE");

endmodule

`default_nettype wire

/* verif/tb_sdram_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_sdram_subsystem;

  logic        cpu_clk, reset_n, read, write;
  logic [24:0] address;
  logic [3:0]  be;
  logic [31:0] data_in, databus_in, data_out, databus_out;
  logic        ready, cs_n, ras_n, cas_n, we_n, cke, dq_oe;
  logic [1:0]  ba;
  logic [12:0] addrbus_out;
  logic [3:0]  dqm;
  logic [31:0] seed;
  int          errors, startup, pre_before;
  logic        stalled;

  sdram_subsystem UUT (.*);

  sdram_model model (.*);

  sdram_checker chk (.*);

  bind sdram_cmd_exec sdram_exec_props u_props (
    .cpu_clk(cpu_clk), .reset_n(reset_n), .cs_n(cs_n), .ras_n(ras_n),
    .cas_n(cas_n), .we_n(we_n), .addrbus_out(addrbus_out), .dq_oe(dq_oe)
  );

  always #20 cpu_clk = ~cpu_clk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [24:0] make_addr(input int bank, input int row, input int col);
    return {2'(bank), 13'(row), 10'(col)};
  endfunction

  task automatic check_value(input string name, input int expected, input int actual);
    if (expected != actual) begin
      errors++;
      $display("FAIL %s expected %0d actual %0d", name, expected, actual);
    end
  endtask

  task automatic wait_ready(input int limit);
    int n;
    n = 0;
    while (!ready && !stalled) begin
      @(posedge cpu_clk);
      #2;
      n++;
      if (n >= limit) begin
        stalled = 1'b1;
        $display("timeout: ready did not rise within %0d cycles", limit);
      end
    end
  endtask

  task automatic access(input logic rd, input logic [24:0] addr, input logic [31:0] data,
                        input logic [3:0] lanes);
    wait_ready(64);
    if (stalled) return;
    read = rd;
    write = !rd;
    address = addr;
    data_in = data;
    be = lanes;
    @(posedge cpu_clk); // taken here.
    #2;
    read = 1'b0;
    write = 1'b0;
    address = 25'(xorshift(seed)); // inputs may change afterwards.
  endtask

  initial begin
    cpu_clk = 1'b0;
    reset_n = 1'b0;
    read = 1'b0;
    write = 1'b0;
    address = 25'd0;
    be = 4'd0;
    data_in = 32'd0;
    seed = 32'h5692_7f47;
    errors = 0;
    stalled = 1'b0;
    repeat (3) @(posedge cpu_clk);
    #2;
    reset_n = 1'b1;

    chk.test_name = "power_up";
    startup = 0;
    while (!ready && startup < 25000) begin
      @(posedge cpu_clk);
      #2;
      startup++;
    end
    if (!ready) begin
      stalled = 1'b1;
      $display("timeout: controller never finished power-up");
    end
    if (startup < sdram_cmd_pkg::T_INIT_WAIT) begin
      errors++;
      $display("ready rose after only %0d cycles", startup);
    end
    check_value("power_up_mrs", 1, model.mode_set);
    check_value("power_up_refreshes", sdram_cmd_pkg::INIT_REFRESHES + 1, model.step);

    chk.test_name = "write_read";
    access(1'b0, make_addr(0, 7, 12), 32'hcafe_f00d, 4'hf);
    access(1'b1, make_addr(0, 7, 12), 32'd0, 4'h0);

    chk.test_name = "partial_write";
    access(1'b0, make_addr(2, 3, 5), 32'h1122_3344, 4'hf);
    access(1'b0, make_addr(2, 3, 5), 32'haabb_ccdd, 4'b0101);
    access(1'b1, make_addr(2, 3, 5), 32'd0, 4'h0);
    access(1'b0, make_addr(2, 3, 5), 32'h9900_0000, 4'b1000);
    access(1'b1, make_addr(2, 3, 5), 32'd0, 4'h0);

    chk.test_name = "row_conflict";
    pre_before = model.single_pre;
    access(1'b0, make_addr(1, 5, 40), 32'h0a0a_5050, 4'hf);
    access(1'b0, make_addr(1, 9, 40), 32'h7777_1234, 4'hf);
    access(1'b1, make_addr(1, 5, 40), 32'd0, 4'h0);
    wait_ready(64);
    if (model.single_pre < pre_before + 2) begin
      errors++;
      $display("row conflict did not precharge the bank");
    end

    chk.test_name = "random_mix";
    for (int i = 0; i < 600 && !stalled; i++) begin
      seed = xorshift(seed);
      // four rows and eight columns per bank keep hits and conflicts frequent.
      access(seed[0], make_addr(int'(seed[2:1]), int'(seed[4:3]), int'(seed[7:5])),
             xorshift(seed ^ 32'h1), seed[11:8]);
    end
    wait_ready(64);
    repeat (4) @(posedge cpu_clk);
    if (model.periodic_refs < 1) begin
      errors++;
      $display("no periodic refresh was seen");
    end

    $display("errors: testbench %0d checker %0d model %0d, reads checked %0d",
             errors, chk.errors, model.errors, chk.reads_checked);
    if (errors == 0 && chk.errors == 0 && model.errors == 0 && !stalled) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sdram_subsystem.f */
verilog/sdram_cmd_pkg.sv
verilog/sdram_addr_pkg.sv
verilog/sdram_init_seq.sv
verilog/sdram_req_decode.sv
verilog/sdram_cmd_exec.sv
verilog/sdram_read_capture.sv
verilog/sdram_subsystem.sv
verif/sdram_model.sv
verif/sdram_checker.sv
verif/sdram_exec_props.sv
verif/tb_sdram_subsystem.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_sdram_subsystem
FILELIST = sdram_subsystem.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
